// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int addr_width      = 64;  // pc and memory address
  localparam int inst_width      = 32;  // one alpha instruction
  localparam int mem_word_width  = 64;  // memory word, two instructions
  localparam int imem_depth_log2 = 8;   // 256 words indexed by pc[10:3]
  localparam int imem_latency    = 2;   // accepted request to valid response

  // queue entries, also the cap on entries plus requests in flight
  localparam int fetch_queue_depth = 4;
  localparam int fq_ptr_width      = $clog2(fetch_queue_depth);
  localparam int fq_cnt_width      = $clog2(fetch_queue_depth + 1);  // holds 0..depth

  localparam logic [fq_cnt_width-1:0] fq_full_count = fq_cnt_width'(fetch_queue_depth);

  localparam logic [addr_width-1:0] reset_pc = '0;  // first fetch address

  ////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;    // condition / link register
    logic [20:0] disp;  // branch displacement
  } br_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;    // base register
    logic [15:0] disp;  // memory displacement
  } mem_fmt_t;

  // one 32-bit word, two decodings
  typedef union packed {
    br_fmt_t  br;
    mem_fmt_t mem;
  } inst_word_t;

  // branch opcodes are 0x30..0x3f, top two opcode bits set
  localparam logic [5:0] branch_opcode_mask = 6'b11_0000;

  function automatic logic is_branch_op(input logic [5:0] opcode);
    return (opcode & branch_opcode_mask) == branch_opcode_mask;
  endfunction

endpackage

`default_nettype wire

// File: design/imem_if.sv
`default_nettype none

interface imem_if
  import fetch_pkg::*;
();

  logic                      req;    // accepted on every edge where high, no ready
  logic [addr_width-1:0]     addr;   // 8-byte aligned
  logic                      valid;  // one-cycle strobe, imem_latency after req
  logic [mem_word_width-1:0] data;   // both halves of the word

  // fetch side issues requests
  modport fetch (
    output req,
    output addr,
    input  valid,
    input  data
  );

  // memory side answers in order
  modport mem (
    input  req,
    input  addr,
    output valid,
    output data
  );

endinterface

`default_nettype wire

// File: design/imem.sv
`default_nettype none

module imem
  import fetch_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  imem_if.mem                       mem,      // read request / response
  input  logic                      wr_en,    // load port
  input  logic [addr_width-1:0]     wr_addr,
  input  logic [mem_word_width-1:0] wr_data
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  logic [mem_word_width-1:0] ram [2**imem_depth_log2];

  logic [imem_depth_log2-1:0] rd_idx;  // word index of the read
  logic [imem_depth_log2-1:0] wr_idx;  // word index of the load

  // response pipeline, one stage per cycle of latency
  logic [imem_latency-1:0]   vld_pipe;
  logic [mem_word_width-1:0] data_pipe [imem_latency];

  // byte address to word index, upper bits ignored
  assign rd_idx = mem.addr[imem_depth_log2+2:3];
  assign wr_idx = wr_addr[imem_depth_log2+2:3];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      ram[wr_idx] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // read pipeline
  ////////////////////////////////////////

  // valid bits carry control, so they clear on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= mem.req;  // capture the request
      for (int i = 1; i < imem_latency; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  // data read every cycle, qualified by vld_pipe at the end
  always_ff @(posedge clock) begin
    data_pipe[0] <= ram[rd_idx];  // same-edge write gives old word
    for (int i = 1; i < imem_latency; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // last stage drives the response
  assign mem.valid = vld_pipe[imem_latency-1];
  assign mem.data  = data_pipe[imem_latency-1];

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`default_nettype none

module fetch_stage
  import fetch_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  imem_if.fetch                   imem,           // request / response to memory
  input  logic                    retire_valid,
  input  logic                    retire_branch,
  input  logic                    retire_taken,
  input  logic [addr_width-1:0]   retire_target,  // redirect address
  output logic                    push,           // queue write
  output logic [addr_width-1:0]   push_pc,
  output logic [addr_width-1:0]   push_npc,
  output logic [inst_width-1:0]   push_inst,
  output logic                    flush,          // empties the queue
  input  logic [fq_cnt_width-1:0] count           // queue occupancy, for credits
);

  logic                    redirect;       // taken branch at retire
  logic [addr_width-1:0]   req_pc;         // runs ahead of the responses
  logic                    issue;          // request this cycle
  logic [fq_cnt_width:0]   credits_used;   // queue entries + in flight
  logic [fq_cnt_width-1:0] inflight_cnt;
  logic [fq_cnt_width-1:0] inflight_next;
  logic [fq_cnt_width-1:0] drop_cnt;       // old-path responses still to come
  logic                    dropping;
  logic [addr_width-1:0]   pc_pipe [imem_latency];  // pc of each request in flight
  logic [addr_width-1:0]   resp_pc;        // pc paired with the current response

  ////////////////////////////////////////
  // redirect
  ////////////////////////////////////////

  assign redirect = retire_valid & retire_branch & retire_taken;  // all three needed
  assign flush    = redirect;

  ////////////////////////////////////////
  // request issue
  ////////////////////////////////////////

  // one request per free slot, none in the redirect cycle (old path)
  assign credits_used = {1'b0, count} + {1'b0, inflight_cnt};
  assign issue        = ~redirect & (credits_used < {1'b0, fq_full_count});

  assign imem.req  = issue;
  assign imem.addr = {req_pc[addr_width-1:3], 3'b000};  // word aligned

  // one request per instruction, so the pc pipeline matches pushes one to one
  always_ff @(posedge clock) begin
    if (reset) begin
      req_pc <= reset_pc;
    end else if (redirect) begin
      req_pc <= retire_target;
    end else if (issue) begin
      req_pc <= req_pc + addr_width'(4);
    end
  end

  // in-flight count, up on issue and down on response
  assign inflight_next = inflight_cnt + fq_cnt_width'(issue) - fq_cnt_width'(imem.valid);

  always_ff @(posedge clock) begin
    if (reset) begin
      inflight_cnt <= '0;
    end else begin
      inflight_cnt <= inflight_next;
    end
  end

  ////////////////////////////////////////
  // stale response drop
  ////////////////////////////////////////

  assign dropping = drop_cnt != '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      drop_cnt <= '0;
    end else if (redirect) begin
      drop_cnt <= inflight_next;  // everything left in flight is old path
    end else if (imem.valid && dropping) begin
      drop_cnt <= drop_cnt - fq_cnt_width'(1);
    end
  end

  // pc pipeline runs alongside the memory latency
  always_ff @(posedge clock) begin
    pc_pipe[0] <= req_pc;
    for (int i = 1; i < imem_latency; i++) begin
      pc_pipe[i] <= pc_pipe[i-1];
    end
  end

  assign resp_pc = pc_pipe[imem_latency-1];

  ////////////////////////////////////////
  // push to queue
  ////////////////////////////////////////

  // a response in the redirect cycle is old path too
  assign push      = imem.valid & ~dropping & ~redirect;
  assign push_pc   = resp_pc;
  assign push_npc  = resp_pc + addr_width'(4);
  assign push_inst = resp_pc[2] ? imem.data[mem_word_width-1:inst_width]  // upper half
                                : imem.data[inst_width-1:0];

endmodule

`default_nettype wire

// File: design/fetch_queue.sv
`default_nettype none

module fetch_queue
  import fetch_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    push,          // write at tail
  input  logic [addr_width-1:0]   push_pc,
  input  logic [addr_width-1:0]   push_npc,
  input  logic [inst_width-1:0]   push_inst,
  input  logic                    flush,         // drop all entries
  input  logic                    dispatch_en,   // consumer ready
  output logic [fq_cnt_width-1:0] count,
  output logic                    if_valid,      // head entry present
  output logic [addr_width-1:0]   if_pc,
  output logic [addr_width-1:0]   if_npc,
  output logic [inst_width-1:0]   if_inst,
  output logic                    if_is_branch,
  output logic [addr_width-1:0]   if_disp        // sign extended
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  logic [addr_width-1:0] pc_mem   [fetch_queue_depth];
  logic [addr_width-1:0] npc_mem  [fetch_queue_depth];
  inst_word_t            inst_mem [fetch_queue_depth];

  logic [fq_ptr_width-1:0] head_ptr;  // oldest entry
  logic [fq_ptr_width-1:0] tail_ptr;  // next free slot
  logic                    pop;
  inst_word_t              head_word;

  assign if_valid = count != '0;
  assign pop      = if_valid & dispatch_en;  // dispatch takes the head

  // payload only, written at tail
  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[tail_ptr]   <= push_pc;
      npc_mem[tail_ptr]  <= push_npc;
      inst_mem[tail_ptr] <= push_inst;
    end
  end

  ////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////

  // fetch credits keep push away from a full queue
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else if (flush) begin
      head_ptr <= '0;  // flush beats push and pop
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        tail_ptr <= tail_ptr + fq_ptr_width'(1);  // wraps, depth is a power of two
      end
      if (pop) begin
        head_ptr <= head_ptr + fq_ptr_width'(1);
      end
      count <= count + fq_cnt_width'(push) - fq_cnt_width'(pop);
    end
  end

  ////////////////////////////////////////
  // head and predecode
  ////////////////////////////////////////

  assign head_word = inst_mem[head_ptr];
  assign if_pc     = pc_mem[head_ptr];
  assign if_npc    = npc_mem[head_ptr];
  assign if_inst   = head_word;

  // opcode sits in the same place in both formats
  assign if_is_branch = is_branch_op(head_word.br.opcode);

  always_comb begin
    if (if_is_branch) begin
      if_disp = {{(addr_width - $bits(head_word.br.disp)){head_word.br.disp[20]}},
                 head_word.br.disp};  // 21-bit branch field
    end else begin
      if_disp = {{(addr_width - $bits(head_word.mem.disp)){head_word.mem.disp[15]}},
                 head_word.mem.disp};  // 16-bit memory field
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  // retire side
  input  logic                      retire_valid,
  input  logic                      retire_branch,
  input  logic                      retire_taken,
  input  logic [addr_width-1:0]     retire_target,
  // dispatch side
  input  logic                      dispatch_en,
  // memory load port
  input  logic                      mem_wr_en,
  input  logic [addr_width-1:0]     mem_wr_addr,
  input  logic [mem_word_width-1:0] mem_wr_data,
  // fetched instruction at queue head
  output logic                      if_valid,
  output logic [addr_width-1:0]     if_pc,
  output logic [addr_width-1:0]     if_npc,
  output logic [inst_width-1:0]     if_inst,
  output logic                      if_is_branch,
  output logic [addr_width-1:0]     if_disp
);

  ////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////

  imem_if imem_bus ();  // fetch stage <-> memory

  // fetch stage -> queue
  logic                    push;
  logic [addr_width-1:0]   push_pc;
  logic [addr_width-1:0]   push_npc;
  logic [inst_width-1:0]   push_inst;
  logic                    flush;
  logic [fq_cnt_width-1:0] count;  // back to fetch for credits

  fetch_stage fetch_stage_inst (
    .clock         (clock),
    .reset         (reset),
    .imem          (imem_bus.fetch),
    .retire_valid  (retire_valid),
    .retire_branch (retire_branch),
    .retire_taken  (retire_taken),
    .retire_target (retire_target),
    .push          (push),
    .push_pc       (push_pc),
    .push_npc      (push_npc),
    .push_inst     (push_inst),
    .flush         (flush),
    .count         (count)
  );

  imem imem_inst (
    .clock   (clock),
    .reset   (reset),
    .mem     (imem_bus.mem),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data)
  );

  fetch_queue fetch_queue_inst (
    .clock        (clock),
    .reset        (reset),
    .push         (push),
    .push_pc      (push_pc),
    .push_npc     (push_npc),
    .push_inst    (push_inst),
    .flush        (flush),
    .dispatch_en  (dispatch_en),
    .count        (count),
    .if_valid     (if_valid),
    .if_pc        (if_pc),
    .if_npc       (if_npc),
    .if_inst      (if_inst),
    .if_is_branch (if_is_branch),
    .if_disp      (if_disp)
  );

endmodule

`default_nettype wire

// File: verification/fetch_unit_chk.sv
`default_nettype none

module fetch_unit_chk
  import fetch_pkg::*;
(
  input wire logic                    clock,
  input wire logic                    reset,
  input wire logic [fq_cnt_width-1:0] count,         // queue occupancy
  input wire logic [fq_cnt_width-1:0] inflight_cnt,  // requests not yet answered
  input wire logic                    flush,
  input wire logic                    if_valid
);

  int unsigned fail_count = 0;  // read by the testbench summary

  ////////////////////////////////////////
  // queue and credit invariants
  ////////////////////////////////////////

  a_count_cap: assert property (@(posedge clock) disable iff (reset)
    count <= fq_full_count)
  else begin
    fail_count++;
    $error("queue count above depth");
  end

  // entries plus requests in flight stay within the queue size
  a_credit_cap: assert property (@(posedge clock) disable iff (reset)
    ({1'b0, count} + {1'b0, inflight_cnt}) <= {1'b0, fq_full_count})
  else begin
    fail_count++;
    $error("queue entries plus requests in flight above depth");
  end

  a_flush_empty: assert property (@(posedge clock) disable iff (reset)
    flush |=> !if_valid)  // head gone right after a redirect
  else begin
    fail_count++;
    $error("head still valid after flush");
  end

endmodule

// credits come from the fetch stage, the head from the queue
bind fetch_unit fetch_unit_chk unit_chk (
  .clock        (clock),
  .reset        (reset),
  .count        (count),
  .inflight_cnt (fetch_stage_inst.inflight_cnt),
  .flush        (flush),
  .if_valid     (if_valid)
);

`default_nettype wire

// File: verification/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb
  import fetch_pkg::*;
();

  localparam int unsigned seq_dispatches    = 120;  // dispatch_en held high
  localparam int unsigned bp_dispatches     = 200;  // random back-pressure
  localparam int unsigned ignore_dispatches = 100;  // retires that must not redirect
  localparam int unsigned redirect_count    = 20;
  localparam int unsigned max_gap           = 12;   // dispatches between redirects
  localparam int unsigned planned = seq_dispatches + bp_dispatches + ignore_dispatches
                                    + redirect_count * max_gap;
  localparam int unsigned timeout_cycles = planned * 20 + 200;

  logic                      clock;
  logic                      reset;
  logic                      retire_valid;
  logic                      retire_branch;
  logic                      retire_taken;
  logic [addr_width-1:0]     retire_target;
  logic                      dispatch_en;
  logic                      mem_wr_en;
  logic [addr_width-1:0]     mem_wr_addr;
  logic [mem_word_width-1:0] mem_wr_data;
  logic                      if_valid;
  logic [addr_width-1:0]     if_pc;
  logic [addr_width-1:0]     if_npc;
  logic [inst_width-1:0]     if_inst;
  logic                      if_is_branch;
  logic [addr_width-1:0]     if_disp;

  logic [mem_word_width-1:0] mem_model [256];  // copy of what gets loaded
  logic [addr_width-1:0]     model_pc;         // next pc expected at dispatch
  logic [inst_width-1:0]     exp_inst;
  logic                      exp_branch;
  logic [addr_width-1:0]     exp_disp;
  int unsigned               dispatch_count;
  int unsigned               error_count;
  int unsigned               assert_count;
  logic                      load_done;

  fetch_unit fetch_unit_inst (
    .clock, .reset, .retire_valid, .retire_branch, .retire_taken, .retire_target,
    .dispatch_en, .mem_wr_en, .mem_wr_addr, .mem_wr_data,
    .if_valid, .if_pc, .if_npc, .if_inst, .if_is_branch, .if_disp
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  ////////////////////////////////////////
  // reference model and check
  ////////////////////////////////////////

  // instruction at pc, plus its predecode by the alpha rules
  function automatic void expected_fetch(input logic [63:0] pc, output logic [31:0] inst,
                                         output logic is_br, output logic [63:0] disp);
    logic [63:0] word;
    word  = mem_model[pc[10:3]];              // 256 words, upper bits ignored
    inst  = pc[2] ? word[63:32] : word[31:0];
    is_br = inst[31:30] == 2'b11;             // opcodes 0x30..0x3f
    if (is_br) begin
      disp = {{43{inst[20]}}, inst[20:0]};
    end else begin
      disp = {{48{inst[15]}}, inst[15:0]};
    end
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // compare on every dispatch edge, then follow redirects
  always @(posedge clock) begin
    if (!reset) begin
      if (if_valid && dispatch_en) begin
        expected_fetch(model_pc, exp_inst, exp_branch, exp_disp);
        check_value("pc", if_pc, model_pc);
        check_value("npc", if_npc, model_pc + 64'd4);
        check_value("inst", 64'(if_inst), 64'(exp_inst));
        check_value("is_branch", 64'(if_is_branch), 64'(exp_branch));
        check_value("disp", if_disp, exp_disp);
        model_pc = model_pc + 64'd4;
        dispatch_count <= dispatch_count + 1;
      end
      if (retire_valid && retire_branch && retire_taken) begin
        model_pc = retire_target;  // dispatch on this edge was still old path
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // one word per cycle, fetch reads at most half a word per cycle behind it
  initial begin
    @(posedge clock);
    for (int unsigned w = 0; w < 256; w++) begin
      mem_wr_en   <= 1'b1;
      mem_wr_addr <= {53'd0, w[7:0], 3'b000};
      mem_wr_data <= mem_model[w[7:0]];
      @(posedge clock);
    end
    mem_wr_en <= 1'b0;
    load_done <= 1'b1;
  end

  task automatic run_stream(input int unsigned until_count, input bit random_dispatch,
                            input bit noisy_retire);
    logic [2:0] flags;
    while (dispatch_count < until_count) begin
      @(posedge clock);
      dispatch_en <= random_dispatch ? ($urandom_range(0, 1) == 32'd1) : 1'b1;
      flags = noisy_retire ? 3'($urandom_range(0, 6)) : 3'b000;  // never all three
      retire_valid  <= flags[0];
      retire_branch <= flags[1];
      retire_taken  <= flags[2];
      retire_target <= {$urandom, $urandom} & ~64'h3;
    end
  endtask

  task automatic redirect_to(input logic [63:0] target);
    @(posedge clock);
    retire_valid  <= 1'b1;
    retire_branch <= 1'b1;
    retire_taken  <= 1'b1;
    retire_target <= target;
    dispatch_en   <= ($urandom_range(0, 1) == 32'd1);
    @(posedge clock);
    retire_valid  <= 1'b0;
    retire_branch <= 1'b0;
    retire_taken  <= 1'b0;
  endtask

  initial begin
    reset          = 1'b1;
    retire_valid   = 1'b0;
    retire_branch  = 1'b0;
    retire_taken   = 1'b0;
    retire_target  = '0;
    dispatch_en    = 1'b0;
    mem_wr_en      = 1'b0;
    mem_wr_addr    = '0;
    mem_wr_data    = '0;
    model_pc       = reset_pc;
    dispatch_count = 0;
    error_count    = 0;
    load_done      = 1'b0;
    void'($urandom(32'hd119));
    for (int unsigned w = 0; w < 256; w++) begin
      mem_model[w] = {$urandom, $urandom};
    end

    repeat (4) @(posedge clock);
    reset       <= 1'b0;
    dispatch_en <= 1'b1;
    // request, memory and push before the first head
    repeat (imem_latency + 1) begin
      @(posedge clock);
      check_value("if_valid before first fetch", 64'(if_valid), 64'd0);
    end

    run_stream(seq_dispatches, 1'b0, 1'b0);
    run_stream(seq_dispatches + bp_dispatches, 1'b1, 1'b0);
    run_stream(seq_dispatches + bp_dispatches + ignore_dispatches, 1'b1, 1'b1);

    wait (load_done);  // memory stays fixed from here on
    for (int unsigned r = 0; r < redirect_count; r++) begin
      redirect_to({$urandom, $urandom} & ~64'h3);
      run_stream(dispatch_count + $urandom_range(1, max_gap), 1'b1, 1'b0);
    end

    assert_count = fetch_unit_inst.unit_chk.fail_count;
    $display("summary: %0d dispatches, %0d errors, %0d assertion failures",
             dispatch_count, error_count, assert_count);
    if (error_count == 0 && assert_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/fetch_pkg.sv
design/imem_if.sv
design/imem.sv
design/fetch_stage.sv
design/fetch_queue.sv
design/fetch_unit.sv
verification/fetch_unit_chk.sv
verification/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
